/* Makefile */
VERILATOR  ?= verilator
TOP        ?= dcache_tb
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* logic/axi_burst_mem.sv */
`timescale 1ns/1ps

module axi_burst_mem #(
	parameter int MEM_WORDS  = 4096,
	parameter int RESP_DELAY = 2
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [dcache_pkg::ADDR_W-1:0]  araddr,
	input  logic                           arvalid,
	output logic                           arready,
	output logic [dcache_pkg::DATA_W-1:0]  rdata,
	output logic                           rvalid,
	output logic                           rlast,
	input  logic [dcache_pkg::ADDR_W-1:0]  awaddr,
	input  logic                           awvalid,
	output logic                           awready,
	input  logic [dcache_pkg::DATA_W-1:0]  wdata,
	input  logic [dcache_pkg::STRB_W-1:0]  wstrb,
	input  logic                           wvalid,
	output logic                           wready,
	output logic                           bvalid,
	output logic [1:0]                     bresp
);

	// word index is taken modulo MEM_WORDS which is a power of two
	localparam int IDX_W = $clog2(MEM_WORDS);
	localparam int DLY_W = $clog2(RESP_DELAY + 2);
	// last beat of a line burst
	localparam logic [2:0] LAST_BEAT = 3'(dcache_pkg::LINE_BEATS - 1);
	localparam logic [1:0] M_IDLE  = 2'd0;
	localparam logic [1:0] M_READ  = 2'd1;
	localparam logic [1:0] M_WDATA = 2'd2;
	localparam logic [1:0] M_WRESP = 2'd3;

	logic [1:0] state;
	logic [DLY_W-1:0] dly_cnt;
	logic [IDX_W-1:0] word_idx;
	logic [2:0] beat;
	logic [dcache_pkg::DATA_W-1:0] mem [MEM_WORDS];
	logic addr_ok;

	// address accepted once it has waited RESP_DELAY cycles
	assign addr_ok = (state == M_IDLE) && (dly_cnt == DLY_W'(RESP_DELAY));
	assign arready = addr_ok && arvalid;
	assign awready = addr_ok && awvalid;
	assign rvalid  = (state == M_READ);
	assign rlast   = rvalid && (beat == LAST_BEAT);
	// bursts walk the line upward from its aligned base
	assign rdata   = mem[{word_idx[IDX_W-1:3], beat}];
	assign wready  = (state == M_WDATA);
	assign bvalid  = (state == M_WRESP);
	assign bresp   = 2'b00;

	always_ff @(posedge clk) begin
		if (rst || state != M_IDLE || !(arvalid || awvalid)) begin
			dly_cnt <= '0;
		end else if (!addr_ok) begin
			dly_cnt <= dly_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= M_IDLE;
			beat  <= 3'd0;
		end else begin
			case (state)
				M_IDLE: begin
					if (arready) begin
						state <= M_READ;
					end else if (awready) begin
						state <= M_WDATA;
					end
				end
				M_READ: begin
					// beat wraps back to zero after the eighth
					beat <= beat + 3'd1;
					if (beat == LAST_BEAT) state <= M_IDLE;
				end
				M_WDATA: if (wvalid) state <= M_WRESP;
				default: state <= M_IDLE;
			endcase
		end
	end

	// latched address of the current burst or write
	always_ff @(posedge clk) begin
		if (arready) begin
			word_idx <= araddr[IDX_W+2:3];
		end else if (awready) begin
			word_idx <= awaddr[IDX_W+2:3];
		end
	end

	// reset fills word k with {~k, k} and writes merge by byte strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < MEM_WORDS; k++) begin
				mem[k] <= {~32'(k), 32'(k)};
			end
		end else if (wvalid && wready) begin
			for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
				if (wstrb[b]) mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
			end
		end
	end

endmodule

/* logic/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                valid,
	input  dcache_pkg::dcache_addr_u            addr,
	input  logic                                wren,
	input  logic [dcache_pkg::DATA_W-1:0]       din,
	input  logic [dcache_pkg::DATA_W-1:0]       mask,
	output logic                                ready,
	output logic [dcache_pkg::DATA_W-1:0]       dout,
	input  logic [dcache_pkg::NUM_WAYS-1:0]     hit_way,
	output logic                                fill_en,
	output logic [dcache_pkg::NUM_WAYS-1:0]     fill_way,
	output logic [dcache_pkg::NUM_WAYS-1:0]     sram_cen,
	output logic                                sram_wen,
	output logic [dcache_pkg::LINE_W-1:0]       sram_bwen,
	output logic [5:0]                          sram_row,
	output logic [dcache_pkg::LINE_W-1:0]       sram_wdata,
	input  logic [dcache_pkg::LINE_W-1:0]       sram_rdata0,
	input  logic [dcache_pkg::LINE_W-1:0]       sram_rdata1,
	input  logic [dcache_pkg::LINE_W-1:0]       sram_rdata2,
	input  logic [dcache_pkg::LINE_W-1:0]       sram_rdata3,
	output logic [dcache_pkg::ADDR_W-1:0]       araddr,
	output logic                                arvalid,
	input  logic                                arready,
	input  logic [dcache_pkg::DATA_W-1:0]       rdata,
	input  logic                                rvalid,
	input  logic                                rlast,
	output logic [dcache_pkg::ADDR_W-1:0]       awaddr,
	output logic                                awvalid,
	input  logic                                awready,
	output logic [dcache_pkg::DATA_W-1:0]       wdata,
	output logic [dcache_pkg::STRB_W-1:0]       wstrb,
	output logic                                wvalid,
	input  logic                                wready,
	input  logic                                bvalid,
	input  logic [1:0]                          bresp
);

	localparam logic [1:0] S_IDLE  = 2'd0;
	localparam logic [1:0] S_FILL  = 2'd1;
	localparam logic [1:0] S_WDATA = 2'd2;
	localparam logic [1:0] S_WRESP = 2'd3;
	localparam logic [dcache_pkg::DATA_W-1:0] ONES = '1;

	logic [1:0] state, state_nxt;
	logic [2:0] beat_cnt;
	logic [dcache_pkg::NUM_WAYS-1:0] victim, hit_q;
	logic [dcache_pkg::LINE_W-1:0] sram_line [dcache_pkg::NUM_WAYS];
	logic [dcache_pkg::LINE_W-1:0] line_sel;
	logic b_done, hit, req, resp_ok, fill_beat;

	assign hit       = |hit_way;
	// nothing new starts in the cycle ready is high
	assign req       = valid && !ready && (state == S_IDLE);
	// response may arrive while the refetch address is still stalled
	assign resp_ok   = (bvalid && (bresp == 2'b00)) || b_done;
	assign fill_beat = (state == S_FILL) && rvalid;

	// read miss from idle, write miss after the write response
	assign arvalid = (req && !wren && !hit) || ((state == S_WRESP) && resp_ok && !hit);
	assign awvalid = req && wren;
	assign wvalid  = (state == S_WDATA);
	assign araddr  = {addr.raw[dcache_pkg::ADDR_W-1:6], 6'b0};
	assign awaddr  = addr.raw;
	assign wdata   = din;
	assign fill_en  = fill_beat && rlast;
	assign fill_way = victim;

	// mask lanes are all ones or all zeros, bit 0 of each lane is enough
	always_comb begin
		for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
			wstrb[b] = mask[8*b];
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE: begin
				if (arvalid && arready) begin
					state_nxt = S_FILL;
				end else if (awvalid && awready) begin
					state_nxt = S_WDATA;
				end
			end
			S_FILL:  if (rvalid && rlast) state_nxt = S_IDLE;
			S_WDATA: if (wready) state_nxt = S_WRESP;
			default: begin
				if (resp_ok && hit) begin
					state_nxt = S_IDLE;
				end else if (resp_ok && arready) begin
					state_nxt = S_FILL;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= S_IDLE;
			victim <= 4'b0001;
			ready  <= 1'b0;
			hit_q  <= '0;
			b_done <= 1'b0;
		end else begin
			state  <= state_nxt;
			// victim rotates while idle and is frozen through a fill
			if (state == S_IDLE) begin
				victim <= {victim[dcache_pkg::NUM_WAYS-2:0], victim[dcache_pkg::NUM_WAYS-1]};
			end
			// read hit, write hit after bvalid, or write miss after rlast
			ready  <= (req && !wren && hit) || ((state == S_WRESP) && resp_ok && hit) ||
				(fill_beat && rlast && wren);
			hit_q  <= (req && !wren) ? hit_way : '0;
			b_done <= (state == S_WRESP) && resp_ok && (state_nxt == S_WRESP);
		end
	end

	// beat counter only runs inside a fill
	always_ff @(posedge clk) begin
		if (rst || state != S_FILL) begin
			beat_cnt <= 3'd0;
		end else if (rvalid) begin
			beat_cnt <= beat_cnt + 3'd1;
		end
	end

	// beat k goes to row k/2, even beats low half, odd beats high half
	always_comb begin
		sram_cen   = '1;
		sram_wen   = 1'b1;
		sram_bwen  = '1;
		sram_row   = {addr.fields.set_idx, addr.fields.row};
		sram_wdata = {din, din};
		if (fill_beat) begin
			sram_cen   = ~victim;
			sram_wen   = 1'b0;
			sram_row   = {addr.fields.set_idx, beat_cnt[2:1]};
			sram_wdata = {rdata, rdata};
			sram_bwen  = beat_cnt[0] ? {~ONES, ONES} : {ONES, ~ONES};
		end else if (req && hit) begin
			// read or write of the hitting way
			sram_cen = ~hit_way;
			sram_wen = !wren;
			if (wren) begin
				sram_bwen = addr.fields.half ? {~mask, ONES} : {ONES, ~mask};
			end
		end
	end

	assign sram_line[0] = sram_rdata0;
	assign sram_line[1] = sram_rdata1;
	assign sram_line[2] = sram_rdata2;
	assign sram_line[3] = sram_rdata3;

	// the way captured with ready picks the row, addr picks the half
	always_comb begin
		line_sel = '0;
		for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
			if (hit_q[w]) begin
				line_sel = sram_line[w];
			end
		end
	end

	assign dout = addr.fields.half ? line_sel[127:64] : line_sel[63:0];

endmodule

/* logic/dcache_data_sram.sv */
`timescale 1ns/1ps

module dcache_data_sram (
	input  logic         clk,
	input  logic         cen,
	input  logic         wen,
	input  logic [127:0] bwen,
	input  logic [5:0]   row,
	input  logic [127:0] wdata,
	output logic [127:0] rdata
);

	// 16 sets times 4 rows of 128 bits
	logic [127:0] mem [64];

	always_ff @(posedge clk) begin
		if (!cen) begin
			if (!wen) begin
				// bwen low bits take new data, high bits keep old contents
				mem[row] <= (mem[row] & bwen) | (wdata & ~bwen);
			end else begin
				// registered read, output holds until the next read
				rdata <= mem[row];
			end
		end
	end

endmodule

/* logic/dcache_pkg.sv */
package dcache_pkg;

	// bus and datapath widths
	localparam int ADDR_W     = 32;
	localparam int DATA_W     = 64;
	localparam int STRB_W     = 8;

	// one sram row carries two bus beats
	localparam int LINE_W     = 128;

	// cache geometry, 64-byte lines
	localparam int NUM_WAYS   = 4;
	localparam int NUM_SETS   = 16;
	localparam int TAG_W      = 22;
	localparam int LINE_BEATS = 8;

	// request address as the bus sees it and as the cache splits it
	typedef union packed {
		logic [ADDR_W-1:0] raw;
		struct packed {
			logic [TAG_W-1:0]            tag;
			// set selects the line slot in every way
			logic [$clog2(NUM_SETS)-1:0] set_idx;
			// 128-bit row inside the line
			logic [1:0]                  row;
			// which 64-bit half of the row
			logic                        half;
			logic [2:0]                  offset;
		} fields;
	} dcache_addr_u;

endpackage

/* logic/dcache_tag_array.sv */
`timescale 1ns/1ps

module dcache_tag_array (
	input  logic                              clk,
	input  logic                              rst,
	input  dcache_pkg::dcache_addr_u          lookup_addr,
	output logic [dcache_pkg::NUM_WAYS-1:0]   hit_way,
	input  logic                              fill_en,
	input  logic [dcache_pkg::NUM_WAYS-1:0]   fill_way
);

	// one valid bit and one tag per set, per way
	logic [dcache_pkg::NUM_SETS-1:0] valid [dcache_pkg::NUM_WAYS];
	logic [dcache_pkg::TAG_W-1:0]    tags  [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_SETS];

	// valid bits are control state and come up cleared
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
				valid[w] <= '0;
			end
		end else if (fill_en) begin
			for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
				// only the victim way is marked
				if (fill_way[w]) begin
					valid[w][lookup_addr.fields.set_idx] <= 1'b1;
				end
			end
		end
	end

	// tag install on the last beat of a fill
	always_ff @(posedge clk) begin
		if (fill_en) begin
			for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
				if (fill_way[w]) begin
					tags[w][lookup_addr.fields.set_idx] <= lookup_addr.fields.tag;
				end
			end
		end
	end

	// all four ways compared in parallel
	// at most one way can match since a line is only filled on a miss
	always_comb begin
		for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
			hit_way[w] = valid[w][lookup_addr.fields.set_idx] &&
				(tags[w][lookup_addr.fields.set_idx] == lookup_addr.fields.tag);
		end
	end

endmodule

/* logic/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top #(
	parameter int MEM_WORDS  = 4096,
	parameter int RESP_DELAY = 2
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        valid,
	input  logic [31:0] addr,
	input  logic        wren,
	input  logic [63:0] din,
	input  logic [63:0] mask,
	output logic        ready,
	output logic [63:0] dout
);

	// tag array handshake
	logic [3:0] hit_way, fill_way;
	logic fill_en;
	// shared sram control, one enable per way
	logic [3:0] sram_cen;
	logic sram_wen;
	logic [127:0] sram_bwen, sram_wdata;
	logic [5:0] sram_row;
	logic [127:0] sram_rdata [4];
	// memory bus
	logic [31:0] araddr, awaddr;
	logic arvalid, arready, rvalid, rlast, awvalid, awready;
	logic wvalid, wready, bvalid;
	logic [63:0] rdata, wdata;
	logic [7:0] wstrb;
	logic [1:0] bresp;

	dcache_ctrl i_ctrl (
		.clk, .rst, .valid, .addr, .wren, .din, .mask, .ready, .dout,
		.hit_way, .fill_en, .fill_way,
		.sram_cen, .sram_wen, .sram_bwen, .sram_row, .sram_wdata,
		.sram_rdata0(sram_rdata[0]), .sram_rdata1(sram_rdata[1]),
		.sram_rdata2(sram_rdata[2]), .sram_rdata3(sram_rdata[3]),
		.araddr, .arvalid, .arready, .rdata, .rvalid, .rlast,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready, .bvalid, .bresp
	);

	dcache_tag_array i_tags (
		.clk, .rst, .lookup_addr(addr), .hit_way, .fill_en, .fill_way
	);

	// one data sram per way, all sharing row, data and mask
	for (genvar w = 0; w < 4; w++) begin : g_way
		dcache_data_sram i_sram (
			.clk, .cen(sram_cen[w]), .wen(sram_wen), .bwen(sram_bwen),
			.row(sram_row), .wdata(sram_wdata), .rdata(sram_rdata[w])
		);
	end

	axi_burst_mem #(.MEM_WORDS(MEM_WORDS), .RESP_DELAY(RESP_DELAY)) i_mem (
		.clk, .rst, .araddr, .arvalid, .arready, .rdata, .rvalid, .rlast,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready, .bvalid, .bresp
	);

endmodule

/* sim/dcache_props.sv */
`timescale 1ns/1ps

module dcache_props (
	input logic                            clk,
	input logic                            rst,
	input logic                            ready,
	input logic                            arvalid,
	input logic                            awvalid,
	input logic [dcache_pkg::NUM_WAYS-1:0] hit_way
);

	// ready is a one-cycle pulse, never two in a row
	a_ready_pulse: assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
		else $error("ready stayed high for two cycles");

	// read and write address channels are never requested together
	a_one_channel: assert property (@(posedge clk) disable iff (rst) !(arvalid && awvalid))
		else $error("arvalid and awvalid high in the same cycle");

	// a line lives in at most one way
	a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_way))
		else $error("hit_way has more than one bit set");

	// first cycle out of reset has no response
	a_reset_ready: assert property (@(posedge clk) rst |=> !ready)
		else $error("ready high right after reset");

endmodule

// attach to every controller in the design
bind dcache_ctrl dcache_props i_props (
	.clk, .rst, .ready, .arvalid, .awvalid, .hit_way
);

/* sim/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

	localparam int MEM_WORDS        = 4096;
	localparam int RESP_DELAY       = 2;
	localparam int RST_CYCLES       = 5;
	localparam int CYCLES_PER_ENTRY = 40;
	localparam bit OP_RD            = 1'b0;
	localparam bit OP_WR            = 1'b1;

	logic clk, rst, valid, wren, ready;
	logic [31:0] addr;
	logic [63:0] din, mask, dout;

	// stimulus table with one queue per column
	bit          op_q [$];
	logic [31:0] addr_q [$];
	logic [63:0] data_q [$];
	logic [63:0] mask_q [$];
	// expected column marking reads that must hit in one cycle
	bit          exp_hit_q [$];

	// holds only words touched by writes while all others follow the reset rule
	logic [63:0] shadow [int];
	int cycles = 0;
	int cycle_limit = 0;

	dcache_top #(.MEM_WORDS(MEM_WORDS), .RESP_DELAY(RESP_DELAY)) i_dut (
		.clk, .rst, .valid, .addr, .wren, .din, .mask, .ready, .dout
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// run length bounded by table size
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: no response after %0d cycles", cycle_limit);
			$display("Done: errors found");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// bus word index wrapping with the memory size
	function automatic int word_index(input logic [31:0] a);
		return int'(a[31:3]) % MEM_WORDS;
	endfunction

	// word k resets to ~k over k
	function automatic logic [63:0] shadow_read(input logic [31:0] a);
		int k;
		k = word_index(a);
		if (shadow.exists(k)) begin
			return shadow[k];
		end
		return {~32'(k), 32'(k)};
	endfunction

	// byte-lane merge where each mask lane is all ones or all zeros
	task automatic shadow_write(input logic [31:0] a, input logic [63:0] d,
			input logic [63:0] m);
		shadow[word_index(a)] = (shadow_read(a) & ~m) | (d & m);
	endtask

	task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("[ERROR] %0t: %s: got %h, expected %h", $time, what, actual, expected);
			$display("Done: errors found");
			$fatal(1, "data check failed");
		end
	endtask

	task automatic add_entry(input bit op, input logic [31:0] a, input bit rnd,
			input logic [63:0] d, input logic [63:0] m, input bit exp_hit);
		op_q.push_back(op);
		addr_q.push_back(a);
		// random data drawn at build time so the sequence is fixed by the seed
		data_q.push_back(rnd ? {$urandom, $urandom} : d);
		mask_q.push_back(m);
		exp_hit_q.push_back(exp_hit);
	endtask

	task automatic build_table();
		// two read misses on a lower half then an upper half
		add_entry(OP_RD, 32'h0000_0040, 1'b0, '0, '0, 1'b0);
		add_entry(OP_RD, 32'h0000_00c8, 1'b0, '0, '0, 1'b0);
		// the same lines again as hits
		add_entry(OP_RD, 32'h0000_0048, 1'b0, '0, '0, 1'b1);
		add_entry(OP_RD, 32'h0000_0078, 1'b0, '0, '0, 1'b1);
		add_entry(OP_RD, 32'h0000_0060, 1'b0, '0, '0, 1'b1);
		add_entry(OP_RD, 32'h0000_00f0, 1'b0, '0, '0, 1'b1);
		// partial write hit followed by a read back
		add_entry(OP_WR, 32'h0000_0050, 1'b1, '0, 64'h0000_ffff_0000_ff00, 1'b0);
		add_entry(OP_RD, 32'h0000_0050, 1'b0, '0, '0, 1'b1);
		// write miss allocates and the neighbour keeps the reset value
		add_entry(OP_WR, 32'h0000_02a8, 1'b1, '0, 64'hff00_0000_00ff_ffff, 1'b0);
		add_entry(OP_RD, 32'h0000_02a8, 1'b0, '0, '0, 1'b1);
		add_entry(OP_RD, 32'h0000_02b0, 1'b0, '0, '0, 1'b1);
		// five lines in set 4 read in two rounds so there are more lines than ways
		for (int r = 0; r < 2; r++) begin
			for (int n = 0; n < 5; n++) begin
				add_entry(OP_RD, 32'h0000_0100 + 32'(n * 32'h400) + 32'(8 * n),
					1'b0, '0, '0, 1'b0);
			end
		end
		// stacked writes to one word with different masks
		add_entry(OP_WR, 32'h0000_1388, 1'b1, '0, 64'h0000_0000_ffff_ffff, 1'b0);
		add_entry(OP_WR, 32'h0000_1388, 1'b1, '0, 64'hff00_ff00_ff00_ff00, 1'b0);
		add_entry(OP_WR, 32'h0000_1388, 1'b1, '0, 64'h00ff_0000_0000_00ff, 1'b0);
		add_entry(OP_RD, 32'h0000_1388, 1'b0, '0, '0, 1'b1);
	endtask

	// called on a falling edge and returns on a falling edge
	task automatic apply_entry(input int i);
		int wait_cycles;
		logic [63:0] expected;
		expected = shadow_read(addr_q[i]);
		valid = 1'b1;
		wren  = op_q[i];
		addr  = addr_q[i];
		din   = data_q[i];
		mask  = mask_q[i];
		if (op_q[i] == OP_WR) begin
			shadow_write(addr_q[i], data_q[i], mask_q[i]);
		end
		wait_cycles = 0;
		do begin
			@(negedge clk);
			wait_cycles++;
		end while (!ready);
		// dout only means something on reads
		if (op_q[i] == OP_RD) begin
			check_equal(dout, expected, $sformatf("read data at %h", addr_q[i]));
			if (exp_hit_q[i]) begin
				check_equal(64'(wait_cycles), 64'd1, $sformatf("hit latency at %h", addr_q[i]));
			end
		end
		// one idle cycle between requests
		valid = 1'b0;
		@(negedge clk);
	endtask

	initial begin
		rst   = 1'b1;
		valid = 1'b0;
		wren  = 1'b0;
		addr  = '0;
		din   = '0;
		mask  = '0;
		void'($urandom(32'h073d2daa));
		build_table();
		cycle_limit = op_q.size() * CYCLES_PER_ENTRY + RST_CYCLES;
		repeat (RST_CYCLES) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < op_q.size(); i++) begin
			apply_entry(i);
		end
		$display("Done: no errors");
		$finish;
	end

endmodule

/* sources.f */
logic/dcache_pkg.sv
logic/dcache_data_sram.sv
logic/dcache_tag_array.sv
logic/dcache_ctrl.sv
logic/axi_burst_mem.sv
logic/dcache_top.sv
sim/dcache_props.sv
sim/dcache_tb.sv
